/* Bender.yml */
package:
  name: victim_cache

sources:
  - verilog/cache_pkg.sv
  - verilog/lane_merge.sv
  - verilog/direct_map_store.sv
  - verilog/victim_buffer.sv
  - verilog/cache_ctrl.sv
  - verilog/cache_top.sv
  - target: simulation
    files:
      - bench/mem_model.sv
      - bench/cache_tb.sv

/* bench/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;

    localparam int N_ROWS    = 25;
    localparam int SEED      = 98;
    localparam int TIMEOUT   = N_ROWS * (cache_pkg::MEM_DELAY + 10) * 10;  // ns
    localparam int MEM_BYTES = (1 << cache_pkg::BLOCK_W) * 16;

    typedef enum int {K_STORE, K_MISS, K_HIT, K_VIC, K_WB} kind_t;

    logic                   clk;
    logic                   rst_n;
    cache_pkg::word_t       cpu_addr;
    cache_pkg::word_t       cpu_data_out;
    cache_pkg::access_t     byte_selection;
    logic                   cpu_wr_re;
    cache_pkg::word_t       cpu_data_in;
    logic                   cpu_ready;
    logic                   cpu_wait;
    cache_pkg::line_t       mem_data_out;
    cache_pkg::block_addr_t mem_addr;
    cache_pkg::line_t       mem_data_in;
    logic                   mem_wren;
    int                     wr_count;

    cache_pkg::word_t   row_addr [N_ROWS];
    cache_pkg::access_t row_size [N_ROWS];
    logic               row_wr   [N_ROWS];
    cache_pkg::word_t   row_data [N_ROWS];
    kind_t              row_kind [N_ROWS];
    int                 n_rows;
    int                 cur_row;
    logic [7:0]         shadow [MEM_BYTES];  // Byte image of what memory should hold
    int                 word_errs, line_errs, flag_errs;

    cache_top i_cache_top (.*);
    mem_model #(.SEED(SEED)) i_mem_model (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_word(input cache_pkg::word_t got, input cache_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            word_errs++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            flag_errs++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Written line must match the shadow image of its block
    task automatic check_line(input cache_pkg::line_t got, input cache_pkg::block_addr_t blk);
        cache_pkg::line_t exp;
        for (int i = 0; i < 16; i++)
            exp[8*i +: 8] = shadow[int'(blk) * 16 + i];
        if (got !== exp) begin
            line_errs++;
            $display("MISMATCH at %0t: write-back block %h got %h expected %h",
                     $time, blk, got, exp);
        end
    endtask

    function automatic int size_bytes(input cache_pkg::access_t size);
        case (size)
            cache_pkg::ACC_WORD: return 4;
            cache_pkg::ACC_HALF: return 2;
            cache_pkg::ACC_BYTE: return 1;
            default:             return 0;
        endcase
    endfunction

    function automatic cache_pkg::word_t expected_load(input cache_pkg::word_t addr,
                                                       input cache_pkg::access_t size);
        cache_pkg::word_t val;
        val = '0;  // Zero-extended
        for (int i = 0; i < size_bytes(size); i++)
            val[8*i +: 8] = shadow[addr[17:0] + i];
        return val;
    endfunction

    task automatic apply_store(input cache_pkg::word_t addr, input cache_pkg::access_t size,
                               input cache_pkg::word_t data);
        for (int i = 0; i < size_bytes(size); i++)
            shadow[addr[17:0] + i] = data[8*i +: 8];
    endtask

    task automatic preset_shadow();
        int seed;
        cache_pkg::word_t r;
        seed = SEED;  // Same sequence as the memory model
        for (int blk = 0; blk < (1 << cache_pkg::BLOCK_W); blk++)
            for (int w = 0; w < 4; w++) begin
                r = $random(seed);
                for (int b = 0; b < 4; b++)
                    shadow[blk*16 + w*4 + b] = r[8*b +: 8];
            end
    endtask

    task automatic add_row(input cache_pkg::word_t addr, input cache_pkg::access_t size,
                           input logic wr, input cache_pkg::word_t data, input kind_t kind);
        row_addr[n_rows] = addr;
        row_size[n_rows] = size;
        row_wr[n_rows]   = wr;
        row_data[n_rows] = data;
        row_kind[n_rows] = kind;
        n_rows++;
    endtask

    task automatic build_table();
        add_row(32'h0000_0100, cache_pkg::ACC_WORD, 1'b0, 32'h0, K_MISS);  // Fresh lines
        add_row(32'h0000_0206, cache_pkg::ACC_HALF, 1'b0, 32'h0, K_MISS);
        add_row(32'h0000_030d, cache_pkg::ACC_BYTE, 1'b0, 32'h0, K_MISS);
        add_row(32'h0000_0101, cache_pkg::ACC_BYTE, 1'b1, 32'hffff_ffa5, K_STORE);
        add_row(32'h0000_0106, cache_pkg::ACC_HALF, 1'b1, 32'h5555_beef, K_STORE);
        add_row(32'h0000_0108, cache_pkg::ACC_WORD, 1'b1, 32'h1234_5678, K_STORE);
        add_row(32'h0000_0100, cache_pkg::ACC_WORD, 1'b0, 32'h0, K_HIT);
        add_row(32'h0000_0104, cache_pkg::ACC_WORD, 1'b0, 32'h0, K_HIT);
        add_row(32'h0000_0108, cache_pkg::ACC_WORD, 1'b0, 32'h0, K_HIT);
        add_row(32'h0000_010c, cache_pkg::ACC_BYTE, 1'b0, 32'h0, K_HIT);
        add_row(32'h0000_0900, cache_pkg::ACC_WORD, 1'b0, 32'h0, K_MISS);  // Same index with tag 1
        add_row(32'h0000_0100, cache_pkg::ACC_WORD, 1'b0, 32'h0, K_VIC);
        add_row(32'h0000_0108, cache_pkg::ACC_WORD, 1'b0, 32'h0, K_HIT);
        // Dirty lines at index 0x40 with tags 1 to 9
        add_row(32'h0000_0c00, cache_pkg::ACC_WORD, 1'b1, 32'hd00d_0001, K_STORE);
        add_row(32'h0000_1400, cache_pkg::ACC_WORD, 1'b1, 32'hd00d_0002, K_STORE);
        add_row(32'h0000_1c00, cache_pkg::ACC_WORD, 1'b1, 32'hd00d_0003, K_STORE);
        add_row(32'h0000_2400, cache_pkg::ACC_WORD, 1'b1, 32'hd00d_0004, K_STORE);
        add_row(32'h0000_2c00, cache_pkg::ACC_WORD, 1'b1, 32'hd00d_0005, K_STORE);
        add_row(32'h0000_3400, cache_pkg::ACC_WORD, 1'b1, 32'hd00d_0006, K_STORE);
        add_row(32'h0000_3c00, cache_pkg::ACC_WORD, 1'b1, 32'hd00d_0007, K_STORE);
        add_row(32'h0000_4400, cache_pkg::ACC_WORD, 1'b1, 32'hd00d_0008, K_STORE);
        add_row(32'h0000_4c00, cache_pkg::ACC_WORD, 1'b1, 32'hd00d_0009, K_STORE);
        add_row(32'h0000_5400, cache_pkg::ACC_WORD, 1'b0, 32'h0, K_WB);  // Evicts dirty tag 1
        add_row(32'h0000_0c00, cache_pkg::ACC_WORD, 1'b0, 32'h0, K_WB);  // Back from memory
        add_row(32'h0000_0c02, cache_pkg::ACC_HALF, 1'b0, 32'h0, K_HIT);
    endtask

    task automatic report_counts();
        $display("Errors: %0d word, %0d line, %0d flag", word_errs, line_errs, flag_errs);
    endtask

    always @(negedge clk) begin
        if (rst_n && mem_wren)
            check_line(mem_data_in, mem_addr);
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: row %0d never saw cpu_ready", cur_row);
        report_counts();
        $display("Test failures found");
        $finish;
    end

    initial begin
        cache_pkg::word_t exp_load;
        int cycles;
        int wb_before;
        rst_n          = 1'b0;
        cpu_addr       = '0;
        cpu_data_out   = '0;
        byte_selection = cache_pkg::ACC_NONE;
        cpu_wr_re      = 1'b0;
        word_errs      = 0;
        line_errs      = 0;
        flag_errs      = 0;
        n_rows         = 0;
        cur_row        = -1;
        preset_shadow();
        build_table();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_flag(cpu_wait, 1'b0, "cpu_wait after reset");
        check_flag(cpu_ready, 1'b0, "cpu_ready after reset");
        check_flag(mem_wren, 1'b0, "mem_wren after reset");

        for (int r = 0; r < N_ROWS; r++) begin
            cur_row   = r;
            wb_before = wr_count;
            exp_load  = expected_load(row_addr[r], row_size[r]);
            if (row_wr[r])
                apply_store(row_addr[r], row_size[r], row_data[r]);
            cpu_addr       = row_addr[r];
            cpu_data_out   = row_data[r];
            byte_selection = row_size[r];
            cpu_wr_re      = row_wr[r];
            cycles = 0;
            do begin
                @(negedge clk);
                cycles++;
                check_flag(cpu_wait, 1'b1, $sformatf("row %0d cpu_wait while busy", r));
            end while (cpu_ready !== 1'b1);
            if (row_kind[r] != K_STORE)
                check_word(cpu_data_in, exp_load, $sformatf("row %0d load data", r));
            if (row_kind[r] == K_HIT)
                check_word(cycles, 32'd1, $sformatf("row %0d hit latency", r));
            if (row_kind[r] == K_VIC)
                check_word(cycles, 32'd2, $sformatf("row %0d swap latency", r));
            check_word(wr_count - wb_before, (row_kind[r] == K_WB) ? 32'd1 : 32'd0,
                       $sformatf("row %0d write-back count", r));
            byte_selection = cache_pkg::ACC_NONE;  // Drop in the ready cycle
            cpu_wr_re      = 1'b0;
            @(negedge clk);
            check_flag(cpu_ready, 1'b0, $sformatf("row %0d cpu_ready after pulse", r));
            check_flag(cpu_wait, 1'b0, $sformatf("row %0d cpu_wait after ready", r));
        end

        report_counts();
        if (word_errs + line_errs + flag_errs == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* bench/mem_model.sv */
`timescale 1ns/1ps

module mem_model #(
    parameter int SEED = 98
) (
    input  logic                   clk,
    input  cache_pkg::block_addr_t mem_addr,
    input  cache_pkg::line_t       mem_data_in,
    input  logic                   mem_wren,
    output cache_pkg::line_t       mem_data_out,
    output int                     wr_count
);

    cache_pkg::line_t       mem [1 << cache_pkg::BLOCK_W];
    cache_pkg::block_addr_t last_addr;
    int                     stable;  // Edges seen with mem_addr unchanged

    // Random preset word by word in ascending block order
    initial begin
        int seed;
        seed = SEED;
        for (int blk = 0; blk < (1 << cache_pkg::BLOCK_W); blk++)
            for (int w = 0; w < 4; w++)
                mem[blk][32*w +: 32] = $random(seed);
        wr_count = 0;
        stable   = 0;
    end

    always @(posedge clk) begin
        if (mem_wren) begin
            mem[mem_addr] <= mem_data_in;
            wr_count      <= wr_count + 1;  // Write strobes seen
        end
        if (mem_addr === last_addr) begin
            if (stable < cache_pkg::MEM_DELAY)
                stable <= stable + 1;
        end else begin
            stable <= 0;
        end
        last_addr <= mem_addr;
    end

    // Data shows up MEM_DELAY cycles after the address settles
    assign mem_data_out = (mem_addr === last_addr && stable >= cache_pkg::MEM_DELAY - 1) ?
                          mem[mem_addr] : 'x;

endmodule

/* flist.f */
verilog/cache_pkg.sv
verilog/lane_merge.sv
verilog/direct_map_store.sv
verilog/victim_buffer.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
bench/mem_model.sv
bench/cache_tb.sv

/* verilog/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,
    input  cache_pkg::word_t                cpu_addr,
    input  cache_pkg::word_t                cpu_data_out,
    input  cache_pkg::access_t              byte_selection,
    input  logic                            cpu_wr_re,
    output cache_pkg::word_t                cpu_data_in,
    output logic                            cpu_ready,
    output logic                            cpu_wait,
    input  cache_pkg::line_t                mem_data_out,
    output cache_pkg::block_addr_t          mem_addr,
    output cache_pkg::line_t                mem_data_in,
    output logic                            mem_wren,
    output cache_pkg::index_t               dm_rd_index,
    input  cache_pkg::line_t                dm_rd_line,
    input  cache_pkg::tag_t                 dm_rd_tag,
    input  logic                            dm_rd_valid,
    input  logic                            dm_rd_dirty,
    output logic                            dm_wr_en,
    output cache_pkg::index_t               dm_wr_index,
    output cache_pkg::line_t                dm_wr_line,
    output cache_pkg::tag_t                 dm_wr_tag,
    output logic                            dm_wr_dirty,
    output cache_pkg::block_addr_t          vb_lookup_block,
    input  logic                            vb_hit,
    input  logic [cache_pkg::VIC_PTR_W-1:0] vb_hit_slot,
    input  logic [cache_pkg::VIC_PTR_W-1:0] vb_fill_slot,
    input  cache_pkg::line_t                vb_slot_line,
    input  cache_pkg::block_addr_t          vb_slot_block,
    input  logic                            vb_slot_valid,
    input  logic                            vb_slot_dirty,
    output logic [cache_pkg::VIC_PTR_W-1:0] vb_rd_slot,
    output logic                            vb_wr_en,
    output logic [cache_pkg::VIC_PTR_W-1:0] vb_wr_slot,
    output cache_pkg::line_t                vb_wr_line,
    output cache_pkg::block_addr_t          vb_wr_block,
    output logic                            vb_wr_valid,
    output logic                            vb_wr_dirty,
    output logic                            vb_advance
);

    cache_pkg::ctrl_state_t        state;
    logic [cache_pkg::DLY_W-1:0]   cnt;
    cache_pkg::block_addr_t        req_block;
    cache_pkg::offset_t            req_offset;
    cache_pkg::access_t            req_size;
    cache_pkg::word_t              req_data;
    logic                          req_write;
    cache_pkg::word_t              load_q;
    cache_pkg::index_t             cur_index;
    cache_pkg::tag_t               cur_tag;
    cache_pkg::offset_t            cur_offset;
    cache_pkg::access_t            cur_size;
    cache_pkg::word_t              cur_data;
    logic                          cur_write;
    cache_pkg::line_t              src_line;
    cache_pkg::line_t              merged;
    cache_pkg::word_t              load_word;
    logic                          idle;
    logic                          main_hit;
    logic                          hit_now;
    logic                          load_en;

    assign idle = (state == cache_pkg::ST_IDLE);

    // Live CPU fields in idle, latched request afterwards
    assign cur_index  = idle ? cpu_addr[10:4]  : req_block[cache_pkg::INDEX_W-1:0];
    assign cur_tag    = idle ? cpu_addr[17:11] : req_block[cache_pkg::BLOCK_W-1:cache_pkg::INDEX_W];
    assign cur_offset = idle ? cpu_addr[3:0]   : req_offset;
    assign cur_size   = idle ? byte_selection  : req_size;
    assign cur_data   = idle ? cpu_data_out    : req_data;
    assign cur_write  = idle ? cpu_wr_re       : req_write;

    assign main_hit = dm_rd_valid && (dm_rd_tag == cur_tag);
    assign hit_now  = idle && (byte_selection != cache_pkg::ACC_NONE) && main_hit;
    assign load_en  = hit_now || state == cache_pkg::ST_SWAP || state == cache_pkg::ST_FILL;

    always_comb begin
        case (state)
            cache_pkg::ST_SWAP: src_line = vb_slot_line;
            cache_pkg::ST_FILL: src_line = mem_data_out;
            default:            src_line = dm_rd_line;
        endcase
    end

    lane_merge i_extract (
        .clk(clk), .line(src_line), .offset(cur_offset), .size(cur_size),
        .store_data(cur_data), .load_data(load_word), .merged_line()
    );

    lane_merge i_insert (
        .clk(clk), .line(src_line), .offset(cur_offset), .size(cur_size),
        .store_data(cur_data), .load_data(), .merged_line(merged)
    );

    // Main array port
    assign dm_rd_index = cur_index;
    assign dm_wr_index = cur_index;
    assign dm_wr_en    = (hit_now && cpu_wr_re) || state == cache_pkg::ST_SWAP ||
                         state == cache_pkg::ST_FILL;
    assign dm_wr_line  = cur_write ? merged : src_line;
    assign dm_wr_tag   = cur_tag;
    assign dm_wr_dirty = cur_write || (state == cache_pkg::ST_SWAP && vb_slot_dirty);

    // Victim port, the old main line moves out on swap and fill
    assign vb_lookup_block = {cur_tag, cur_index};
    assign vb_rd_slot  = (state == cache_pkg::ST_SWAP) ? vb_hit_slot : vb_fill_slot;
    assign vb_wr_slot  = vb_rd_slot;
    assign vb_advance  = (state == cache_pkg::ST_FILL) && dm_rd_valid;
    assign vb_wr_en    = (state == cache_pkg::ST_SWAP) || vb_advance;
    assign vb_wr_line  = dm_rd_line;
    assign vb_wr_block = {dm_rd_tag, cur_index};
    assign vb_wr_valid = dm_rd_valid;
    assign vb_wr_dirty = dm_rd_dirty;

    assign mem_addr    = (state == cache_pkg::ST_WB) ? vb_slot_block : req_block;
    assign mem_data_in = vb_slot_line;
    assign cpu_data_in = load_q;
    assign cpu_wait    = !idle;

    always_ff @(posedge clk) begin
        if (idle) begin
            req_block  <= {cpu_addr[17:11], cpu_addr[10:4]};
            req_offset <= cpu_addr[3:0];
            req_size   <= byte_selection;
            req_data   <= cpu_data_out;
            req_write  <= cpu_wr_re;
        end
        if (load_en)
            load_q <= load_word;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= cache_pkg::ST_IDLE;
            cnt       <= '0;
            cpu_ready <= 1'b0;
            mem_wren  <= 1'b0;
        end else begin
            cpu_ready <= 1'b0;
            mem_wren  <= 1'b0;
            case (state)
                cache_pkg::ST_IDLE: begin
                    cnt <= '0;
                    if (hit_now) begin
                        state     <= cache_pkg::ST_DONE;
                        cpu_ready <= 1'b1;
                    end else if (byte_selection != cache_pkg::ACC_NONE) begin
                        if (vb_hit) begin
                            state <= cache_pkg::ST_SWAP;
                        end else if (vb_slot_valid && vb_slot_dirty) begin
                            state    <= cache_pkg::ST_WB;
                            mem_wren <= 1'b1;
                        end else begin
                            state <= cache_pkg::ST_MEM_WAIT;
                        end
                    end
                end
                cache_pkg::ST_WB: state <= cache_pkg::ST_MEM_WAIT;
                cache_pkg::ST_MEM_WAIT: begin
                    if (cnt == cache_pkg::DLY_LAST)
                        state <= cache_pkg::ST_FILL;
                    cnt <= cnt + 1'b1;
                end
                cache_pkg::ST_FILL, cache_pkg::ST_SWAP: begin
                    state     <= cache_pkg::ST_DONE;
                    cpu_ready <= 1'b1;
                end
                default: state <= cache_pkg::ST_IDLE;  // ST_DONE
            endcase
        end
    end

    a_wren_pulse: assert property (@(posedge clk) disable iff (!rst_n) mem_wren |=> !mem_wren)
        else $error("mem_wren held for two cycles");

    a_ready_done: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_ready |-> state == cache_pkg::ST_DONE)
        else $error("cpu_ready outside ST_DONE");

endmodule

/* verilog/cache_pkg.sv */
package cache_pkg;

    localparam int WORD_W    = 32;
    localparam int LINE_W    = 128;
    localparam int OFFSET_W  = 4;
    localparam int INDEX_W   = 7;
    localparam int TAG_W     = 7;
    localparam int BLOCK_W   = TAG_W + INDEX_W;  // Also the memory address width
    localparam int LINES     = 128;
    localparam int VIC_LINES = 8;
    localparam int VIC_PTR_W = 3;
    localparam int MEM_DELAY = 5;                // Address stable to read data valid

    // Miss wait counter
    localparam int DLY_W = $clog2(MEM_DELAY);
    localparam logic [DLY_W-1:0] DLY_LAST = DLY_W'(MEM_DELAY - 1);

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [LINE_W-1:0]   line_t;
    typedef logic [BLOCK_W-1:0]  block_addr_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    typedef enum logic [1:0] {
        ACC_NONE = 2'b00,  // No request
        ACC_BYTE = 2'b01,
        ACC_HALF = 2'b10,
        ACC_WORD = 2'b11
    } access_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WB,        // Dirty victim slot to memory
        ST_MEM_WAIT,
        ST_FILL,
        ST_SWAP,      // Main line and victim slot exchange
        ST_DONE
    } ctrl_state_t;

endpackage

/* verilog/cache_top.sv */
`timescale 1ns/1ps

module cache_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cache_pkg::word_t       cpu_addr,
    input  cache_pkg::word_t       cpu_data_out,
    input  cache_pkg::access_t     byte_selection,
    input  logic                   cpu_wr_re,
    output cache_pkg::word_t       cpu_data_in,
    output logic                   cpu_ready,
    output logic                   cpu_wait,
    input  cache_pkg::line_t       mem_data_out,
    output cache_pkg::block_addr_t mem_addr,
    output cache_pkg::line_t       mem_data_in,
    output logic                   mem_wren
);

    cache_pkg::index_t               dm_rd_index, dm_wr_index;
    cache_pkg::line_t                dm_rd_line, dm_wr_line;
    cache_pkg::tag_t                 dm_rd_tag, dm_wr_tag;
    logic                            dm_rd_valid, dm_rd_dirty, dm_wr_en, dm_wr_dirty;
    cache_pkg::block_addr_t          vb_lookup_block, vb_slot_block, vb_wr_block;
    cache_pkg::line_t                vb_slot_line, vb_wr_line;
    logic [cache_pkg::VIC_PTR_W-1:0] vb_hit_slot, vb_fill_slot, vb_rd_slot, vb_wr_slot;
    logic                            vb_hit, vb_slot_valid, vb_slot_dirty;
    logic                            vb_wr_en, vb_wr_valid, vb_wr_dirty, vb_advance;

    cache_ctrl i_cache_ctrl (
        .clk(clk), .rst_n(rst_n),
        .cpu_addr(cpu_addr), .cpu_data_out(cpu_data_out),
        .byte_selection(byte_selection), .cpu_wr_re(cpu_wr_re),
        .cpu_data_in(cpu_data_in), .cpu_ready(cpu_ready), .cpu_wait(cpu_wait),
        .mem_data_out(mem_data_out), .mem_addr(mem_addr),
        .mem_data_in(mem_data_in), .mem_wren(mem_wren),
        .dm_rd_index(dm_rd_index), .dm_rd_line(dm_rd_line), .dm_rd_tag(dm_rd_tag),
        .dm_rd_valid(dm_rd_valid), .dm_rd_dirty(dm_rd_dirty), .dm_wr_en(dm_wr_en),
        .dm_wr_index(dm_wr_index), .dm_wr_line(dm_wr_line), .dm_wr_tag(dm_wr_tag),
        .dm_wr_dirty(dm_wr_dirty),
        .vb_lookup_block(vb_lookup_block), .vb_hit(vb_hit), .vb_hit_slot(vb_hit_slot),
        .vb_fill_slot(vb_fill_slot), .vb_slot_line(vb_slot_line),
        .vb_slot_block(vb_slot_block), .vb_slot_valid(vb_slot_valid),
        .vb_slot_dirty(vb_slot_dirty), .vb_rd_slot(vb_rd_slot), .vb_wr_en(vb_wr_en),
        .vb_wr_slot(vb_wr_slot), .vb_wr_line(vb_wr_line), .vb_wr_block(vb_wr_block),
        .vb_wr_valid(vb_wr_valid), .vb_wr_dirty(vb_wr_dirty), .vb_advance(vb_advance)
    );

    direct_map_store i_direct_map_store (
        .clk(clk), .rst_n(rst_n),
        .rd_index(dm_rd_index), .rd_line(dm_rd_line), .rd_tag(dm_rd_tag),
        .rd_valid(dm_rd_valid), .rd_dirty(dm_rd_dirty),
        .wr_en(dm_wr_en), .wr_index(dm_wr_index), .wr_line(dm_wr_line),
        .wr_tag(dm_wr_tag), .wr_dirty(dm_wr_dirty)
    );

    victim_buffer i_victim_buffer (
        .clk(clk), .rst_n(rst_n),
        .lookup_block(vb_lookup_block), .hit(vb_hit), .hit_slot(vb_hit_slot),
        .fill_slot(vb_fill_slot), .slot_line(vb_slot_line), .slot_block(vb_slot_block),
        .slot_valid(vb_slot_valid), .slot_dirty(vb_slot_dirty), .rd_slot(vb_rd_slot),
        .wr_en(vb_wr_en), .wr_slot(vb_wr_slot), .wr_line(vb_wr_line),
        .wr_block(vb_wr_block), .wr_valid(vb_wr_valid), .wr_dirty(vb_wr_dirty),
        .advance(vb_advance)
    );

endmodule

/* verilog/direct_map_store.sv */
`timescale 1ns/1ps

module direct_map_store (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::index_t   rd_index,
    output cache_pkg::line_t    rd_line,
    output cache_pkg::tag_t     rd_tag,
    output logic                rd_valid,
    output logic                rd_dirty,
    input  logic                wr_en,
    input  cache_pkg::index_t   wr_index,
    input  cache_pkg::line_t    wr_line,
    input  cache_pkg::tag_t     wr_tag,
    input  logic                wr_dirty
);

    cache_pkg::line_t             line_mem [cache_pkg::LINES];
    cache_pkg::tag_t              tag_mem  [cache_pkg::LINES];
    logic [cache_pkg::LINES-1:0]  valid;
    logic [cache_pkg::LINES-1:0]  dirty;

    // Asynchronous read port
    assign rd_line  = line_mem[rd_index];
    assign rd_tag   = tag_mem[rd_index];
    assign rd_valid = valid[rd_index];
    assign rd_dirty = dirty[rd_index];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            line_mem[wr_index] <= wr_line;
            tag_mem[wr_index]  <= wr_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
            dirty <= '0;
        end else if (wr_en) begin
            valid[wr_index] <= 1'b1;  // Every write installs a line
            dirty[wr_index] <= wr_dirty;
        end
    end

endmodule

/* verilog/lane_merge.sv */
`timescale 1ns/1ps

module lane_merge (
    input  logic               clk,
    input  cache_pkg::line_t   line,
    input  cache_pkg::offset_t offset,
    input  cache_pkg::access_t size,
    input  cache_pkg::word_t   store_data,
    output cache_pkg::word_t   load_data,
    output cache_pkg::line_t   merged_line
);

    cache_pkg::word_t size_mask;
    cache_pkg::line_t shifted;
    cache_pkg::line_t lane_mask;
    cache_pkg::line_t lane_data;
    logic [6:0]       bit_pos;

    always_comb begin
        case (size)
            cache_pkg::ACC_BYTE: size_mask = 32'h0000_00ff;
            cache_pkg::ACC_HALF: size_mask = 32'h0000_ffff;
            cache_pkg::ACC_WORD: size_mask = 32'hffff_ffff;
            default:             size_mask = 32'h0000_0000;
        endcase
    end

    assign bit_pos = {offset, 3'b000};  // Byte offset in bits

    // Load data right-justified and zero-extended
    assign shifted   = line >> bit_pos;
    assign load_data = shifted[cache_pkg::WORD_W-1:0] & size_mask;

    // Only the addressed lanes change on a store
    assign lane_mask = cache_pkg::line_t'(size_mask) << bit_pos;
    assign lane_data = cache_pkg::line_t'(store_data & size_mask) << bit_pos;
    assign merged_line = (line & ~lane_mask) | lane_data;

    // Natural alignment of the CPU access
    a_aligned: assert property (@(posedge clk)
        (size == cache_pkg::ACC_HALF || size == cache_pkg::ACC_WORD) |->
        offset[0] == 1'b0 && (size == cache_pkg::ACC_HALF || offset[1] == 1'b0))
        else $error("misaligned access, offset %0d size %0d", offset, size);

endmodule

/* verilog/victim_buffer.sv */
`timescale 1ns/1ps

module victim_buffer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  cache_pkg::block_addr_t         lookup_block,
    output logic                           hit,
    output logic [cache_pkg::VIC_PTR_W-1:0] hit_slot,
    output logic [cache_pkg::VIC_PTR_W-1:0] fill_slot,
    output cache_pkg::line_t               slot_line,
    output cache_pkg::block_addr_t         slot_block,
    output logic                           slot_valid,
    output logic                           slot_dirty,
    input  logic [cache_pkg::VIC_PTR_W-1:0] rd_slot,
    input  logic                           wr_en,
    input  logic [cache_pkg::VIC_PTR_W-1:0] wr_slot,
    input  cache_pkg::line_t               wr_line,
    input  cache_pkg::block_addr_t         wr_block,
    input  logic                           wr_valid,
    input  logic                           wr_dirty,
    input  logic                           advance
);

    cache_pkg::line_t               line_mem  [cache_pkg::VIC_LINES];
    cache_pkg::block_addr_t         block_mem [cache_pkg::VIC_LINES];
    logic [cache_pkg::VIC_LINES-1:0] valid;
    logic [cache_pkg::VIC_LINES-1:0] dirty;
    logic [cache_pkg::VIC_LINES-1:0] match;
    logic [cache_pkg::VIC_PTR_W-1:0] ptr;

    // Fully associative compare
    always_comb begin
        hit_slot = '0;
        for (int i = 0; i < cache_pkg::VIC_LINES; i++) begin
            match[i] = valid[i] && (block_mem[i] == lookup_block);
            if (match[i])
                hit_slot = i[cache_pkg::VIC_PTR_W-1:0];
        end
    end

    assign hit        = |match;
    assign fill_slot  = ptr;
    assign slot_line  = line_mem[rd_slot];
    assign slot_block = block_mem[rd_slot];
    assign slot_valid = valid[rd_slot];
    assign slot_dirty = dirty[rd_slot];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            line_mem[wr_slot]  <= wr_line;
            block_mem[wr_slot] <= wr_block;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
            dirty <= '0;
            ptr   <= '0;
        end else begin
            if (wr_en) begin
                valid[wr_slot] <= wr_valid;
                dirty[wr_slot] <= wr_dirty;
            end
            if (advance)
                ptr <= ptr + 1'b1;  // Round robin, wraps at VIC_LINES
        end
    end

    // A block lives in at most one slot
    a_unique: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(match))
        else $error("block %h found in several victim slots", lookup_block);

endmodule
